//--- bench/tracker_assert.sv
// concurrent checks on the tracker top level, bound in below
// watches state, wheel commands and the internal steer signal
`timescale 1ns/1ns

module tracker_assert (
  input logic                    clk,
  input logic                    rst,
  input logic                    enable,
  input sensor_pkg::steer_t      steer,
  input motor_pkg::wheel_cmd_t   wheel,
  input motor_pkg::track_state_t state
);

  import sensor_pkg::*;
  import motor_pkg::*;

  // stopped states zero the wheels one edge later
  property stop_zeroes_wheels;
    @(posedge clk) disable iff (rst)
      (state == TRK_OFF || state == TRK_LOST) |=> (wheel == '0);
  endproperty

  // two low enable samples, state must be off
  property enable_low_gives_off;
    @(posedge clk) disable iff (rst)
      (!enable ##1 !enable) |=> (state == TRK_OFF);
  endproperty

  // wheel registered from the previous steer value
  property unequal_only_when_turning;
    @(posedge clk) disable iff (rst)
      (wheel.left_dps != wheel.right_dps) |-> ($past(steer) != STEER_CENTER);
  endproperty

  a_stop: assert property (stop_zeroes_wheels)
    else $error("wheels not zero after an off or lost state");
  a_off: assert property (enable_low_gives_off)
    else $error("state not off after enable held low");
  a_turn: assert property (unequal_only_when_turning)
    else $error("wheels differ while steering is centered");

endmodule

bind tracker_top tracker_assert u_assert (
  .clk    (clk),
  .rst    (rst),
  .enable (enable),
  .steer  (steer),
  .wheel  (wheel),
  .state  (state)
);

//--- bench/tracker_tb.sv
// testbench for the object-following steering controller
// table-driven steps checked against a cycle-accurate reference model
// long miss runs take their proximity from a galois lfsr
`timescale 1ns/1ns
`include "track_macros.svh"

module tracker_tb;

  import sensor_pkg::*;
  import motor_pkg::*;

  // one table step applied reps times
  typedef struct {
    logic      en;    // enable level
    logic      stb;   // pulse new_centroid in the first cycle
    centroid_t cent;
    prox_t     prox;
    logic      rnd;   // take proximity from the lfsr
    int        hold;  // cycles after the strobe cycle
    int        reps;
  } step_t;

  logic         clk;
  logic         rst;
  logic         enable;
  logic         new_centroid;
  cam_sample_t  cam;
  wheel_cmd_t   wheel;
  track_state_t state;

  step_t       steps[$];
  logic [15:0] lfsr;    // random proximity source
  int          errors;
  int          checks;
  int          cycles;
  int          limit;   // timeout in clock cycles

  // reference model registers
  logic [`TRK_MISS_W-1:0] m_miss;
  centroid_t              m_held;
  track_state_t           m_state;
  logic                   m_drive;
  wheel_cmd_t             m_wheel;

  tracker_top UUT (
    .clk          (clk),
    .rst          (rst),
    .enable       (enable),
    .new_centroid (new_centroid),
    .cam          (cam),
    .wheel        (wheel),
    .state        (state)
  );

  always #2 clk = ~clk;  // 4 ns period

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 16'hB400;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // one lfsr step per proximity bit
  task automatic rand_prox(output prox_t p);
    for (int i = 0; i < $bits(prox_t); i++) begin
      p[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // 180 down to 60 in steps of 40 and mirrored negative for near codes
  function automatic dps_t base_speed(input prox_t p);
    int v;
    if (p[2]) begin
      v = -60 - 40 * (int'(p) - 4);
    end else begin
      v = 180 - 40 * int'(p);
    end
    base_speed = dps_t'(v);
  endfunction

  // base moved toward zero by 60 45 30 15 then 15 30 45 60
  function automatic dps_t slow_speed(input prox_t p);
    int trim;
    int v;
    if (p[2]) begin
      trim = 15 * (int'(p) - 3);
      v = int'(base_speed(p)) + trim;  // negative base so add
    end else begin
      trim = 60 - 15 * int'(p);
      v = int'(base_speed(p)) - trim;
    end
    slow_speed = dps_t'(v);
  endfunction

  function automatic steer_t side_of(input centroid_t c);
    if (c[4] && c[3]) begin
      side_of = STEER_CENTER;
    end else if (c[3:0] != 4'h0) begin
      side_of = STEER_LEFT;
    end else begin
      side_of = STEER_RIGHT;
    end
  endfunction

  // inner wheel gets the slow speed and backward swaps sides
  function automatic wheel_cmd_t mixed_wheels(input logic drive, input centroid_t held,
                                              input prox_t p);
    steer_t s;
    s = side_of(held);
    mixed_wheels = '0;
    if (drive) begin
      mixed_wheels.left_dps  = base_speed(p);
      mixed_wheels.right_dps = base_speed(p);
      if (s != STEER_CENTER) begin
        if ((s == STEER_LEFT) != p[2]) begin
          mixed_wheels.left_dps = slow_speed(p);
        end else begin
          mixed_wheels.right_dps = slow_speed(p);
        end
      end
    end
  endfunction

  function automatic track_state_t state_of(input logic en,
                                            input logic [`TRK_MISS_W-1:0] miss);
    if (!en) begin
      state_of = TRK_OFF;
    end else if (&miss) begin
      state_of = TRK_LOST;
    end else if (miss != '0) begin
      state_of = TRK_SEARCH;
    end else begin
      state_of = TRK_FOLLOW;
    end
  endfunction

  // reference model on the same edges as the DUT registers
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      m_miss  <= '0;
      m_held  <= '0;
      m_state <= TRK_OFF;
      m_drive <= 1'b0;
      m_wheel <= '0;
    end else begin
      m_wheel <= mixed_wheels(m_drive, m_held, cam.prox);
      m_state <= state_of(enable, m_miss);
      m_drive <= enable && !(&m_miss);
      if (new_centroid) begin
        if (cam.centroid != '0) begin
          m_miss <= '0;
          m_held <= cam.centroid;
        end else if (!(&m_miss)) begin
          m_miss <= m_miss + 1'b1;
        end
      end
    end
  end

  // run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the test steps did not finish within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic add_row(input logic en, input logic stb, input centroid_t cent,
                         input prox_t prox, input int hold, input int reps,
                         input logic rnd);
    step_t st;
    st.en   = en;
    st.stb  = stb;
    st.cent = cent;
    st.prox = prox;
    st.rnd  = rnd;
    st.hold = hold;
    st.reps = reps;
    steps.push_back(st);
  endtask

  task automatic load_table();
    // after reset then enabled with the zero centroid on the right side
    add_row(1'b0, 1'b0, 8'h00, 3'd0, 3, 1, 1'b0);
    add_row(1'b1, 1'b0, 8'h00, 3'd0, 3, 1, 1'b0);
    // centered at every proximity code
    for (int p = 0; p < 8; p++) begin
      add_row(1'b1, 1'b1, 8'h18, prox_t'(p), 3, 1, 1'b0);
    end
    // left and right in both directions
    add_row(1'b1, 1'b1, 8'h05, 3'd1, 3, 1, 1'b0);
    add_row(1'b1, 1'b1, 8'h05, 3'd6, 3, 1, 1'b0);
    add_row(1'b1, 1'b1, 8'h80, 3'd2, 3, 1, 1'b0);
    add_row(1'b1, 1'b1, 8'h80, 3'd5, 3, 1, 1'b0);
    // misses after a left sighting
    add_row(1'b1, 1'b1, 8'h05, 3'd2, 3, 1, 1'b0);
    add_row(1'b1, 1'b1, 8'h00, 3'd2, 3, 1, 1'b0);   // first miss gives search
    add_row(1'b1, 1'b1, 8'h00, 3'd0, 1, 61, 1'b1);
    add_row(1'b1, 1'b1, 8'h00, 3'd3, 3, 1, 1'b0);   // 63rd miss
    add_row(1'b1, 1'b0, 8'h18, 3'd3, 3, 1, 1'b0);   // unstrobed centroid keeps it lost
    add_row(1'b1, 1'b1, 8'h80, 3'd0, 4, 1, 1'b0);   // object back
    // enable dropped mid-follow then the count survives re-enable
    add_row(1'b0, 1'b0, 8'h80, 3'd1, 3, 1, 1'b0);
    add_row(1'b1, 1'b0, 8'h05, 3'd1, 3, 1, 1'b0);   // unstrobed left ignored
    add_row(1'b1, 1'b1, 8'h00, 3'd4, 1, 63, 1'b1);
    add_row(1'b0, 1'b0, 8'h00, 3'd4, 3, 1, 1'b0);
    add_row(1'b1, 1'b0, 8'h00, 3'd4, 3, 1, 1'b0);   // straight to lost
    add_row(1'b1, 1'b1, 8'h00, 3'd7, 2, 3, 1'b0);   // saturated count holds
  endtask

  task automatic check_outputs(input int row);
    checks++;
    if (wheel !== m_wheel) begin
      errors++;
      $display("[ERROR] %0t ns step %0d: wheel expected L=%0d R=%0d, got L=%0d R=%0d",
               $time, row, m_wheel.left_dps, m_wheel.right_dps,
               wheel.left_dps, wheel.right_dps);
    end
    if (state !== m_state) begin
      errors++;
      $display("[ERROR] %0t ns step %0d: state expected %s, got %s",
               $time, row, m_state.name(), state.name());
    end
  endtask

  // entered and left on a falling edge
  task automatic apply_step(input int row, input step_t st);
    prox_t p;
    for (int r = 0; r < st.reps; r++) begin
      p = st.prox;
      if (st.rnd) begin
        rand_prox(p);
      end
      enable       = st.en;
      cam.centroid = st.cent;
      cam.prox     = p;
      new_centroid = st.stb;
      @(negedge clk);
      new_centroid = 1'b0;  // strobe lasts one cycle
      repeat (st.hold) @(negedge clk);
      check_outputs(row);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    enable       = 1'b0;
    new_centroid = 1'b0;
    cam          = '0;
    lfsr         = 16'd29924;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    load_table();
    limit = 3 + 20;  // reset plus margin
    foreach (steps[i]) begin
      limit += steps[i].reps * (steps[i].hold + 1);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(i, steps[i]);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tracker testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module tracker_tb -o tracker_sim \
  && ./obj_dir/tracker_sim > sim.log 2>&1 \
  || echo "build or simulation stopped early"

[ -f sim.log ] && cat sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- src.f
+incdir+verilog
verilog/sensor_pkg.sv
verilog/motor_pkg.sv
verilog/track_ctrl.sv
verilog/centroid_latch.sv
verilog/speed_table.sv
verilog/wheel_mix.sv
verilog/tracker_top.sv
bench/tracker_assert.sv
bench/tracker_tb.sv

//--- verilog/centroid_latch.sv
// keeps the last nonzero centroid and classifies which side it is on
// steer is registered and tracks a capturing strobe by one edge
`timescale 1ns/1ns

module centroid_latch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  new_centroid,
  input  sensor_pkg::centroid_t centroid,
  output logic                  seen,   // comb, incoming centroid nonzero
  output sensor_pkg::steer_t    steer
);

  import sensor_pkg::*;

  logic      capture;   // strobe with an object in view
  centroid_t held;      // last valid centroid
  centroid_t held_nxt;
  steer_t    side_nxt;  // classification of held_nxt

  assign seen     = (centroid != '0);
  assign capture  = new_centroid & seen;
  assign held_nxt = capture ? centroid : held;  // empty frames keep old value

  // side of the held value
  always_comb begin
    if (held_nxt[4:3] == 2'b11) begin
      side_nxt = STEER_CENTER;  // middle band of the frame
    end else if (held_nxt[3:0] != 4'b0000) begin
      side_nxt = STEER_LEFT;
    end else begin
      side_nxt = STEER_RIGHT;  // also what zero after reset maps to
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      held  <= '0;
      steer <= STEER_RIGHT;
    end else begin
      held  <= held_nxt;
      steer <= side_nxt;  // same edge as the capture
    end
  end

endmodule

//--- verilog/motor_pkg.sv
// types for the motor side: wheel speeds, wheel commands and the
// tracking state reported by the control FSM
`include "track_macros.svh"

package motor_pkg;

  // signed wheel speed in degrees per second
  typedef logic signed [`TRK_DPS_W-1:0] dps_t;

  // command pair sent on to the motor board
  typedef struct packed {
    dps_t left_dps;   // left wheel
    dps_t right_dps;  // right wheel
  } wheel_cmd_t;

  // proximity lookup result
  typedef struct packed {
    dps_t base_dps;  // speed of the outer wheel, or both when centered
    dps_t slow_dps;  // base moved toward zero, for the inner wheel
  } speed_pair_t;

  // control FSM state
  //   off    enable low, wheels stopped
  //   follow object seen on the last strobe
  //   search some frames missed, keep turning toward last side
  //   lost   miss counter saturated, wheels stopped
  typedef enum logic [1:0] {
    TRK_OFF    = 2'd0,
    TRK_FOLLOW = 2'd1,
    TRK_SEARCH = 2'd2,
    TRK_LOST   = 2'd3
  } track_state_t;

endpackage

//--- verilog/sensor_pkg.sv
// types for the camera and range sensor side of the tracker
// centroid and proximity travel together in cam_sample_t
`include "track_macros.svh"

package sensor_pkg;

  // horizontal centroid, zero means nothing in view
  typedef logic [`TRK_CENT_W-1:0] centroid_t;

  // 0 very far .. 7 very near, top bit selects backward motion
  typedef logic [`TRK_PROX_W-1:0] prox_t;

  // one camera + range sample as it enters the top level
  typedef struct packed {
    centroid_t centroid;  // from camera pipeline
    prox_t     prox;      // from range sensor
  } cam_sample_t;

  // which side of the frame the object sits on
  typedef enum logic [1:0] {
    STEER_CENTER = 2'd0,
    STEER_LEFT   = 2'd1,
    STEER_RIGHT  = 2'd2
  } steer_t;

endpackage

//--- verilog/speed_table.sv
// proximity lookup of the base wheel speed and the slow-side speed
// far codes drive forward, near codes (msb set) drive backward
// purely combinational, wheel_mix registers the result
`timescale 1ns/1ns
`include "track_macros.svh"

module speed_table (
  input  sensor_pkg::prox_t       prox,
  output motor_pkg::speed_pair_t  speeds
);

  import motor_pkg::*;

  dps_t base;  // base speed, signed
  dps_t trim;  // side offset magnitude, always positive

  always_comb begin
    base = '0;
    trim = '0;
    case (prox)
      3'd0: begin  // very far, full speed ahead
        base = dps_t'(180);
        trim = dps_t'(60);
      end
      3'd1: begin
        base = dps_t'(140);
        trim = dps_t'(45);
      end
      3'd2: begin
        base = dps_t'(100);
        trim = dps_t'(30);
      end
      3'd3: begin  // close to target distance
        base = dps_t'(60);
        trim = dps_t'(15);
      end
      3'd4: begin  // slightly too close, back off gently
        base = dps_t'(-60);
        trim = dps_t'(15);
      end
      3'd5: begin
        base = dps_t'(-100);
        trim = dps_t'(30);
      end
      3'd6: begin
        base = dps_t'(-140);
        trim = dps_t'(45);
      end
      3'd7: begin  // very near, full speed back
        base = dps_t'(-180);
        trim = dps_t'(60);
      end
    endcase
  end

  assign speeds.base_dps = base;
  // move toward zero: add when going backward, subtract when forward
  assign speeds.slow_dps = prox[`TRK_PROX_W-1] ? base + trim : base - trim;

endmodule

//--- verilog/track_ctrl.sv
// control FSM of the tracker, counts frames without an object and
// decides whether the wheels may turn (drive_en)
// state and drive_en are registered from enable and the miss counter
`timescale 1ns/1ns
`include "track_macros.svh"

module track_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,        // low stops the wheels
  input  logic                    new_centroid,  // one cycle per frame
  input  logic                    seen,          // centroid nonzero this frame
  output logic                    drive_en,
  output motor_pkg::track_state_t state
);

  import motor_pkg::*;

  logic [`TRK_MISS_W-1:0] miss_cnt;   // consecutive empty frames
  logic                   miss_full;  // counter saturated
  track_state_t           state_nxt;

  assign miss_full = &miss_cnt;  // all ones, object lost

  // miss counter, only moves on a frame strobe
  // enable does not clear it, a lost object stays lost across re-enable
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      miss_cnt <= '0;
    end else if (new_centroid) begin
      if (seen) begin
        miss_cnt <= '0;  // object back in view
      end else if (!miss_full) begin
        miss_cnt <= miss_cnt + 1'b1;
      end
      // saturated: hold at all ones
    end
  end

  // next state from enable and current count
  always_comb begin
    if (!enable) begin
      state_nxt = TRK_OFF;
    end else if (miss_full) begin
      state_nxt = TRK_LOST;
    end else if (miss_cnt != '0) begin
      state_nxt = TRK_SEARCH;  // keep heading to last known side
    end else begin
      state_nxt = TRK_FOLLOW;
    end
  end

  // registered state, drive_en alongside so both change on one edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= TRK_OFF;
      drive_en <= 1'b0;
    end else begin
      state    <= state_nxt;
      drive_en <= (state_nxt == TRK_FOLLOW) || (state_nxt == TRK_SEARCH);
    end
  end

endmodule

//--- verilog/track_macros.svh
// fixed widths shared by the tracking controller packages and RTL
// include wherever a width or the miss counter size is needed
`ifndef TRACK_MACROS_SVH
`define TRACK_MACROS_SVH

// wheel speed in signed degrees per second, as the motor board expects
`define TRK_DPS_W 16

// horizontal centroid from the camera pipeline, 0 = no object
`define TRK_CENT_W 8

// range sensor proximity code, msb set means object is near
`define TRK_PROX_W 3

// frames without object before giving up
// 6 bits saturates at 63, roughly 3 s at camera frame rate
`define TRK_MISS_W 6

`endif

//--- verilog/tracker_top.sv
// top of the object-following steering controller
// camera/range sample in, signed wheel commands and FSM state out
// control path is track_ctrl, datapath is latch -> table -> mix
`timescale 1ns/1ns

module tracker_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic                    new_centroid,  // frame strobe
  input  sensor_pkg::cam_sample_t cam,
  output motor_pkg::wheel_cmd_t   wheel,
  output motor_pkg::track_state_t state
);

  import sensor_pkg::*;
  import motor_pkg::*;

  logic        seen;      // object in the current sample
  logic        drive_en;  // wheels allowed to turn
  steer_t      steer;     // side of last valid centroid
  speed_pair_t speeds;    // from proximity lookup

  track_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .enable       (enable),
    .new_centroid (new_centroid),
    .seen         (seen),
    .drive_en     (drive_en),
    .state        (state)
  );

  centroid_latch u_latch (
    .clk          (clk),
    .rst          (rst),
    .new_centroid (new_centroid),
    .centroid     (cam.centroid),
    .seen         (seen),
    .steer        (steer)
  );

  speed_table u_table (
    .prox   (cam.prox),
    .speeds (speeds)
  );

  wheel_mix u_mix (
    .clk      (clk),
    .rst      (rst),
    .drive_en (drive_en),
    .steer    (steer),
    .backward (cam.prox[$bits(prox_t)-1]),  // near codes reverse
    .speeds   (speeds),
    .wheel    (wheel)
  );

endmodule

//--- verilog/wheel_mix.sv
// picks which wheel takes the slow-side speed and registers both
// wheel commands; drive_en low forces the wheels to zero
`timescale 1ns/1ns

module wheel_mix (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   drive_en,  // from control FSM
  input  sensor_pkg::steer_t     steer,
  input  logic                   backward,  // proximity msb
  input  motor_pkg::speed_pair_t speeds,
  output motor_pkg::wheel_cmd_t  wheel
);

  import sensor_pkg::*;
  import motor_pkg::*;

  dps_t left_nxt;
  dps_t right_nxt;

  // turning toward the object means slowing the inner wheel
  // going backward swaps which wheel is inner
  always_comb begin
    left_nxt  = speeds.base_dps;
    right_nxt = speeds.base_dps;
    case (steer)
      STEER_LEFT: begin
        if (backward) begin
          right_nxt = speeds.slow_dps;
        end else begin
          left_nxt = speeds.slow_dps;
        end
      end
      STEER_RIGHT: begin
        if (backward) begin
          left_nxt = speeds.slow_dps;
        end else begin
          right_nxt = speeds.slow_dps;
        end
      end
      default: begin
        // centered, both at base speed
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wheel <= '0;
    end else if (!drive_en) begin
      wheel <= '0;  // off or lost, stop
    end else begin
      wheel.left_dps  <= left_nxt;
      wheel.right_dps <= right_nxt;
    end
  end

endmodule
